// ==== Bender.yml ====
package:
  name: vid_main

sources:
  - include_dirs:
      - .
    files:
      - vid_pkg.sv
      - vid_vram.sv
      - vid_palette.sv
      - vid_gen.sv
      - vid_regs.sv
      - vid_main.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_vid_main.sv

// ==== tb_clk_gen.sv ====
// testbench clock and reset
module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;                             // high from time 0
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb_vid_main.sv ====
// video controller testbench
`include "vid_config.svh"

module tb_vid_main
    import vid_pkg::*;
();

    localparam int FRAME       = `VID_H_TOTAL * `VID_V_TOTAL;   // cycles per frame
    localparam int WPL         = `VID_H_VISIBLE / 2;            // words per line
    localparam int ACK_TIMEOUT = 16;
    localparam int HS_GAP      = `VID_HSYNC_START - `VID_H_VISIBLE;     // de low to hsync
    localparam int HS_LEN      = `VID_HSYNC_END - `VID_HSYNC_START;
    // last de of the frame to vsync
    localparam int VS_GAP      = (`VID_H_TOTAL - `VID_H_VISIBLE)
                                 + (`VID_VSYNC_START - `VID_V_VISIBLE) * `VID_H_TOTAL;

    logic           clk;
    logic           reset_i;
    logic           wb_cyc_i;
    logic           wb_stb_i;
    logic           wb_we_i;
    logic [2:0]     wb_adr_i;
    logic [1:0]     wb_sel_i;
    logic [15:0]    wb_dat_i;
    logic [15:0]    wb_dat_o;
    logic           wb_ack_o;
    logic           bus_intr_o;
    logic [3:0]     red_o;
    logic [3:0]     green_o;
    logic [3:0]     blue_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           dv_de_o;
    logic [11:0]    rgb;

    // reference model state
    logic [15:0]    vram_model [4096];
    logic [11:0]    pal_model [256];
    logic [11:0]    disp_start_model;
    logic [31:0]    lfsr_q;
    logic           rd_check;       // read data compared at ack
    logic [15:0]    rd_expect;
    logic [15:0]    rd_care;
    logic           px_en;
    logic           px_armed;       // pixels compared after a vsync
    int             line_y;
    int             px_k;
    logic           intr_quiet;     // no strobe allowed with mask 0

    assign rgb = {red_o, green_o, blue_o};

    tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(5)) i_tb_clk_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    vid_main i_vid_main (.*);

    task automatic stop_on_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_hang(input string what);
        $display("timeout: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);             // one step per bit
            v = {v[14:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // pixel k of line y from vram word and palette
    function automatic logic [11:0] expected_pixel(input int y, input int k);
        logic [11:0] addr;
        logic [15:0] word;
        logic [7:0]  idx;
        addr = disp_start_model + 12'(y * WPL + k / 2);
        word = vram_model[addr];
        idx  = k[0] ? word[7:0] : word[15:8];       // even column takes high byte
        return pal_model[idx];
    endfunction

    // one wishbone classic transfer held until ack
    task automatic wb_cycle(input logic we, input vid_reg_e adr, input logic [1:0] sel,
                            input logic [15:0] wdata, input logic [15:0] exp_v,
                            input logic [15:0] care);
        logic got;
        got = 1'b0;
        @(posedge clk);
        wb_cyc_i  <= 1'b1;
        wb_stb_i  <= 1'b1;
        wb_we_i   <= we;
        wb_adr_i  <= adr;
        wb_sel_i  <= sel;
        wb_dat_i  <= wdata;
        rd_check  <= !we;
        rd_expect <= exp_v;
        rd_care   <= care;
        for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = wb_ack_o;
        end
        if (!got) report_hang($sformatf("no wishbone ack for register %0d", adr));
        else begin
            @(posedge clk);
            wb_cyc_i <= 1'b0;                       // stb low at least one cycle
            wb_stb_i <= 1'b0;
            rd_check <= 1'b0;
        end
    endtask

    task automatic bus_write(input vid_reg_e adr, input logic [1:0] sel, input logic [15:0] d);
        wb_cycle(1'b1, adr, sel, d, 16'h0000, 16'h0000);
    endtask

    task automatic bus_read(input vid_reg_e adr, input logic [15:0] exp_v,
                            input logic [15:0] care);
        wb_cycle(1'b0, adr, 2'b11, 16'h0000, exp_v, care);
    endtask

    // full writes, byte-select overwrite, read back
    task automatic vram_block_test(input int words);
        logic [11:0] base;
        logic [11:0] a;
        logic [15:0] d;
        logic [1:0]  sel;
        base = 12'(take_bits(12));
        bus_write(REG_VRAM_ADDR, 2'b11, 16'(base));
        for (int i = 0; i < words; i++) begin
            d = take_bits(16);
            vram_model[base + 12'(i)] = d;
            bus_write(REG_VRAM_DATA, 2'b11, d);
        end
        bus_write(REG_VRAM_ADDR, 2'b11, 16'(base));
        for (int i = 0; i < words; i++) begin
            a   = base + 12'(i);
            sel = 2'(take_bits(2));
            d   = take_bits(16);
            if (sel[1]) vram_model[a][15:8] = d[15:8];
            if (sel[0]) vram_model[a][7:0] = d[7:0];
            bus_write(REG_VRAM_DATA, sel, d);
        end
        bus_write(REG_VRAM_ADDR, 2'b11, 16'(base));
        for (int i = 0; i < words; i++) begin
            bus_read(REG_VRAM_DATA, vram_model[base + 12'(i)], 16'hffff);
        end
        bus_read(REG_VRAM_ADDR, 16'(base + 12'(words)), 16'h0fff);  // auto-increment
    endtask

    task automatic xr_test();
        disp_start_model = 12'(take_bits(12));
        bus_write(REG_XR_ADDR, 2'b11, 16'h0000);
        bus_write(REG_XR_DATA, 2'b11, 16'(disp_start_model));
        bus_write(REG_XR_DATA, 2'b11, 16'd3);       // line match on line 3
        bus_write(REG_XR_ADDR, 2'b11, 16'h0000);
        bus_read(REG_XR_DATA, 16'(disp_start_model), 16'hffff);
        bus_read(REG_XR_DATA, 16'd3, 16'hffff);
        bus_read(REG_XR_ADDR, 16'd2, 16'hffff);
        bus_write(REG_XR_ADDR, 2'b11, 16'h8000 | take_bits(8));
        bus_read(REG_XR_DATA, 16'h0000, 16'hffff);  // palette is write only
    endtask

    task automatic load_palette_and_frame();
        logic [15:0] d;
        bus_write(REG_XR_ADDR, 2'b11, 16'h8000);
        for (int i = 0; i < 256; i++) begin
            d = take_bits(12);
            pal_model[i] = d[11:0];
            bus_write(REG_XR_DATA, 2'b11, d);
        end
        bus_write(REG_VRAM_ADDR, 2'b11, 16'(disp_start_model));
        for (int i = 0; i < `VID_V_VISIBLE * WPL; i++) begin
            d = take_bits(16);
            vram_model[disp_start_model + 12'(i)] = d;
            bus_write(REG_VRAM_DATA, 2'b11, d);
        end
    endtask

    task automatic wait_intr_pulse();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < 2 * FRAME && !seen; n++) begin
            @(negedge clk);
            seen = bus_intr_o;
        end
        if (!seen) report_hang("no interrupt strobe within two frames");
    endtask

    // pixel position model following dv_de_o
    always @(posedge clk) begin
        if (reset_i) begin
            line_y   <= 0;
            px_k     <= 0;
            px_armed <= 1'b0;
        end else if (vsync_o) begin
            line_y   <= 0;
            px_k     <= 0;
            px_armed <= px_en;
        end else if (dv_de_o) begin
            px_k <= (px_k == `VID_H_VISIBLE - 1) ? 0 : px_k + 1;
            if (px_k == `VID_H_VISIBLE - 1) line_y <= line_y + 1;
        end
    end

    assert property (@(posedge clk) reset_i |=> (!wb_ack_o && !bus_intr_o && !dv_de_o
                                                 && !hsync_o && !vsync_o && rgb == '0))
        else stop_on_error("output not cleared by reset");
    assert property (@(posedge clk) disable iff (reset_i) wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else stop_on_error("ack without cyc and stb");
    assert property (@(posedge clk) disable iff (reset_i) wb_ack_o |=> !wb_ack_o)
        else stop_on_error("ack longer than one cycle");
    assert property (@(posedge clk) disable iff (reset_i)
                     (wb_ack_o && rd_check) |-> ((wb_dat_o & rd_care) == (rd_expect & rd_care)))
        else stop_on_error($sformatf("read data %h, expected %h", wb_dat_o, rd_expect));
    assert property (@(posedge clk) disable iff (reset_i) !dv_de_o |-> rgb == '0)
        else stop_on_error($sformatf("rgb %h outside display enable", rgb));
    assert property (@(posedge clk) disable iff (reset_i)
                     (dv_de_o && px_armed) |-> rgb == expected_pixel(line_y, px_k))
        else stop_on_error($sformatf("pixel %0d of line %0d is %h", px_k, line_y, rgb));
    assert property (@(posedge clk) disable iff (reset_i)
                     $fell(dv_de_o) |-> ##HS_GAP $rose(hsync_o))
        else stop_on_error("hsync does not start at its pixel after display enable");
    assert property (@(posedge clk) disable iff (reset_i)
                     $rose(hsync_o) |-> ##HS_LEN $fell(hsync_o))
        else stop_on_error("hsync pulse has the wrong width");
    assert property (@(posedge clk) disable iff (reset_i)
                     $rose(vsync_o) |-> ($past(dv_de_o, VS_GAP + 1)
                                         && !$past(dv_de_o, VS_GAP)))
        else stop_on_error("vsync does not start at its line after the visible lines");
    assert property (@(posedge clk) disable iff (reset_i) bus_intr_o |=> !bus_intr_o)
        else stop_on_error("interrupt strobe longer than one cycle");
    assert property (@(posedge clk) disable iff (reset_i) intr_quiet |-> !bus_intr_o)
        else stop_on_error("interrupt strobe with mask 0");

    initial begin
        lfsr_q     = 32'h864f_a03d;
        wb_cyc_i   <= 1'b0;
        wb_stb_i   <= 1'b0;
        wb_we_i    <= 1'b0;
        wb_adr_i   <= '0;
        wb_sel_i   <= '0;
        wb_dat_i   <= '0;
        rd_check   <= 1'b0;
        rd_expect  <= '0;
        rd_care    <= '0;
        px_en      <= 1'b0;
        intr_quiet <= 1'b0;
        for (int n = 0; n < 20 && reset_i !== 1'b0; n++) @(negedge clk);
        if (reset_i !== 1'b0) report_hang("reset never released");
        else begin
            bus_read(REG_INTR, 16'h0000, 16'h0f0d);     // line 0 match may set bit 1
            vram_block_test(16);                        // spans visible and blanking
            vram_block_test(24);
            xr_test();
            load_palette_and_frame();
            px_en <= 1'b1;
            for (int n = 0; n < 2 * FRAME && !px_armed; n++) @(negedge clk);
            if (!px_armed) report_hang("no vsync seen to start pixel checks");
            else begin
                repeat (2 * FRAME) @(posedge clk);
                bus_write(REG_INTR, 2'b11, 16'h0303);   // mask 0 and 1, clear both
                wait_intr_pulse();
                wait_intr_pulse();
                bus_read(REG_INTR, 16'h0303, 16'h0f0f);
                bus_write(REG_INTR, 2'b11, 16'h0300);   // mask off, clear both
                bus_read(REG_INTR, 16'h0000, 16'h0f0f);
                intr_quiet <= 1'b1;
                repeat (2 * FRAME) @(posedge clk);
                $display("SIMULATION PASSED");
                $finish;
            end
        end
    end

endmodule

// ==== vid_config.svh ====
// video controller build constants
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// bus and memory widths
`define VID_DATA_W      16      // vram word, wishbone data
`define VID_VRAM_AW     12      // 4K words of vram
`define VID_PAL_AW      8       // 256 palette entries

// horizontal raster, in pixels
`define VID_H_VISIBLE   16
`define VID_H_TOTAL     24
`define VID_HSYNC_START 18
`define VID_HSYNC_END   21      // first pixel after hsync

// vertical raster, in lines
`define VID_V_VISIBLE   8
`define VID_V_TOTAL     12
`define VID_VSYNC_START 9
`define VID_VSYNC_END   10      // first line after vsync

`define VID_COLOR_W     4       // per rgb component
`define VID_INTR_W      4       // interrupt sources incl. unused

`endif

// ==== vid_gen.sv ====
// raster timing and bitmap fetch
`include "vid_config.svh"

module vid_gen
    import vid_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        xr_wr_i,
    input  logic                        xr_addr_i,      // xr_reg_e
    input  logic [`VID_DATA_W-1:0]      xr_wdata_i,
    input  logic [`VID_DATA_W-1:0]      vram_rdata_i,
    output logic [`VID_DATA_W-1:0]      xr_rdata_o,
    output logic                        video_req_o,
    output logic [`VID_VRAM_AW-1:0]     video_addr_o,
    output logic [`VID_PAL_AW-1:0]      color_index_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output intr_t                       intr_signal_o
);

    localparam int HW  = $clog2(`VID_H_TOTAL);
    localparam int VW  = $clog2(`VID_V_TOTAL);
    localparam int AW  = `VID_VRAM_AW;
    localparam int WPL = `VID_H_VISIBLE / 2;        // vram words per line

    logic [HW-1:0]              h_cnt;
    logic [VW-1:0]              v_cnt;
    logic [`VID_DATA_W-1:0]     disp_start;
    logic [`VID_DATA_W-1:0]     line_intr;
    logic                       visible;
    logic                       hsync;
    logic                       vsync;
    logic                       line_start;
    logic                       fetch_d;            // vram data valid now
    logic [`VID_PAL_AW-1:0]     lo_index;           // odd pixel of the word
    logic [1:0]                 hs_pipe;
    logic [1:0]                 vs_pipe;
    logic [1:0]                 de_pipe;

    // raster counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HW'(`VID_H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(`VID_V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign visible    = (h_cnt < HW'(`VID_H_VISIBLE)) && (v_cnt < VW'(`VID_V_VISIBLE));
    assign hsync      = (h_cnt >= HW'(`VID_HSYNC_START)) && (h_cnt < HW'(`VID_HSYNC_END));
    assign vsync      = (v_cnt >= VW'(`VID_VSYNC_START)) && (v_cnt < VW'(`VID_VSYNC_END));
    assign line_start = (h_cnt == '0);

    // video registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            disp_start <= '0;
            line_intr  <= '0;
        end else if (xr_wr_i) begin
            case (xr_reg_e'(xr_addr_i))
                XR_DISP_START: disp_start <= xr_wdata_i;
                XR_LINE_INTR:  line_intr  <= xr_wdata_i;
                default:       ;
            endcase
        end
    end

    assign xr_rdata_o = (xr_reg_e'(xr_addr_i) == XR_LINE_INTR) ? line_intr : disp_start;

    // one fetch per pixel pair, on even columns
    assign video_req_o  = visible && !h_cnt[0];
    assign video_addr_o = disp_start[AW-1:0] + AW'(v_cnt) * AW'(WPL) + AW'(h_cnt >> 1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_d       <= 1'b0;
            hs_pipe       <= '0;
            vs_pipe       <= '0;
            de_pipe       <= '0;
            intr_signal_o <= '0;
        end else begin
            fetch_d <= video_req_o;
            hs_pipe <= {hs_pipe[0], hsync};         // match fetch plus split
            vs_pipe <= {vs_pipe[0], vsync};
            de_pipe <= {de_pipe[0], visible};
            intr_signal_o <= {{(`VID_INTR_W - 2){1'b0}},
                              line_start && (`VID_DATA_W'(v_cnt) == line_intr),
                              line_start && (v_cnt == VW'(`VID_V_VISIBLE))};
        end
    end

    // high byte first, low byte next cycle
    always_ff @(posedge clk) begin
        if (fetch_d) begin
            color_index_o <= vram_rdata_i[`VID_DATA_W-1 -: `VID_PAL_AW];
            lo_index      <= vram_rdata_i[`VID_PAL_AW-1:0];
        end else begin
            color_index_o <= lo_index;
        end
    end

    assign hsync_o = hs_pipe[1];
    assign vsync_o = vs_pipe[1];
    assign de_o    = de_pipe[1];

endmodule

// ==== vid_main.f ====
+incdir+.
vid_pkg.sv
vid_vram.sv
vid_palette.sv
vid_gen.sv
vid_regs.sv
vid_main.sv
tb_clk_gen.sv
tb_vid_main.sv

// ==== vid_main.sv ====
// bitmap video controller top
`include "vid_config.svh"

module vid_main
    import vid_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [2:0]                  wb_adr_i,       // vid_reg_e
    input  logic [`VID_DATA_W/8-1:0]    wb_sel_i,
    input  logic [`VID_DATA_W-1:0]      wb_dat_i,
    output logic [`VID_DATA_W-1:0]      wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        bus_intr_o,     // one cycle strobe
    output logic [`VID_COLOR_W-1:0]     red_o,
    output logic [`VID_COLOR_W-1:0]     green_o,
    output logic [`VID_COLOR_W-1:0]     blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

    // host side of vram
    logic                       host_req;
    logic                       host_we;
    logic [`VID_DATA_W/8-1:0]   host_be;
    logic [`VID_VRAM_AW-1:0]    host_addr;
    logic [`VID_DATA_W-1:0]     host_wdata;
    logic                       host_grant;
    logic [`VID_DATA_W-1:0]     vram_rdata;     // shared by host and video

    // video side of vram
    logic                       video_req;
    logic [`VID_VRAM_AW-1:0]    video_addr;

    // xr registers and palette writes
    logic                       xr_wr;
    logic                       xr_addr;
    logic [`VID_DATA_W-1:0]     xr_wdata;
    logic [`VID_DATA_W-1:0]     xr_rdata;
    logic                       pal_wr;
    logic [`VID_PAL_AW-1:0]     pal_addr;
    rgb_t                       pal_wdata;
    intr_t                      intr_signal;

    // raster into the palette stage
    logic [`VID_PAL_AW-1:0]     color_index;
    logic                       gen_hsync;
    logic                       gen_vsync;
    logic                       gen_de;

    vid_regs i_vid_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .host_grant_i  (host_grant),
        .vram_rdata_i  (vram_rdata),
        .xr_rdata_i    (xr_rdata),
        .intr_signal_i (intr_signal),
        .host_req_o    (host_req),
        .host_we_o     (host_we),
        .host_be_o     (host_be),
        .host_addr_o   (host_addr),
        .host_wdata_o  (host_wdata),
        .xr_wr_o       (xr_wr),
        .xr_addr_o     (xr_addr),
        .xr_wdata_o    (xr_wdata),
        .pal_wr_o      (pal_wr),
        .pal_addr_o    (pal_addr),
        .pal_wdata_o   (pal_wdata),
        .bus_intr_o    (bus_intr_o)
    );

    vid_vram i_vid_vram (
        .clk          (clk),
        .video_req_i  (video_req),
        .video_addr_i (video_addr),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_be_i    (host_be),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_grant_o (host_grant),
        .rdata_o      (vram_rdata)
    );

    vid_gen i_vid_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .xr_wr_i       (xr_wr),
        .xr_addr_i     (xr_addr),
        .xr_wdata_i    (xr_wdata),
        .vram_rdata_i  (vram_rdata),
        .xr_rdata_o    (xr_rdata),
        .video_req_o   (video_req),
        .video_addr_o  (video_addr),
        .color_index_o (color_index),
        .hsync_o       (gen_hsync),
        .vsync_o       (gen_vsync),
        .de_o          (gen_de),
        .intr_signal_o (intr_signal)
    );

    vid_palette i_vid_palette (
        .clk           (clk),
        .reset_i       (reset_i),
        .pal_wr_i      (pal_wr),
        .pal_addr_i    (pal_addr),
        .pal_wdata_i   (pal_wdata),
        .color_index_i (color_index),
        .hsync_i       (gen_hsync),
        .vsync_i       (gen_vsync),
        .de_i          (gen_de),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

endmodule

// ==== vid_palette.sv ====
// palette lookup and output stage
`include "vid_config.svh"

module vid_palette
    import vid_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        pal_wr_i,
    input  logic [`VID_PAL_AW-1:0]      pal_addr_i,
    input  rgb_t                        pal_wdata_i,
    input  logic [`VID_PAL_AW-1:0]      color_index_i,
    input  logic                        hsync_i,
    input  logic                        vsync_i,
    input  logic                        de_i,
    output logic [`VID_COLOR_W-1:0]     red_o,
    output logic [`VID_COLOR_W-1:0]     green_o,
    output logic [`VID_COLOR_W-1:0]     blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

    rgb_t   pal_mem [1 << `VID_PAL_AW];
    rgb_t   lookup;         // one cycle behind color_index_i
    logic   hs_d;
    logic   vs_d;
    logic   de_d;

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal_mem[pal_addr_i] <= pal_wdata_i;
        end
        lookup <= pal_mem[color_index_i];
    end

    // sync and de follow the lookup, colour blanked outside de
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hs_d    <= 1'b0;
            vs_d    <= 1'b0;
            de_d    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            hs_d    <= hsync_i;
            vs_d    <= vsync_i;
            de_d    <= de_i;
            hsync_o <= hs_d;
            vsync_o <= vs_d;
            dv_de_o <= de_d;
            red_o   <= de_d ? lookup.red   : '0;
            green_o <= de_d ? lookup.green : '0;
            blue_o  <= de_d ? lookup.blue  : '0;
        end
    end

endmodule

// ==== vid_pkg.sv ====
// video controller shared types
`include "vid_config.svh"

package vid_pkg;

    // host register numbers on wb_adr_i
    typedef enum logic [2:0] {
        REG_VRAM_ADDR = 3'd0,
        REG_VRAM_DATA = 3'd1,   // vram at vram addr, auto-increment
        REG_XR_ADDR   = 3'd2,
        REG_XR_DATA   = 3'd3,   // xr reg or palette, auto-increment
        REG_INTR      = 3'd4    // mask and status
    } vid_reg_e;

    // video registers, XR address bit 15 clear
    typedef enum logic [0:0] {
        XR_DISP_START = 1'b0,   // first vram word of frame
        XR_LINE_INTR  = 1'b1    // line for the match interrupt
    } xr_reg_e;

    // host access sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_VRAM_WAIT,           // host_req out, waiting for grant
        ST_VRAM_READ,           // vram read data on the bus
        ST_ACK
    } regs_state_e;

    typedef struct packed {
        logic [`VID_COLOR_W-1:0] red;
        logic [`VID_COLOR_W-1:0] green;
        logic [`VID_COLOR_W-1:0] blue;
    } rgb_t;

    typedef logic [`VID_INTR_W-1:0] intr_t;    // bit 0 vblank, bit 1 line match

endpackage

// ==== vid_regs.sv ====
// host register unit
`include "vid_config.svh"

module vid_regs
    import vid_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [2:0]                  wb_adr_i,
    input  logic [`VID_DATA_W/8-1:0]    wb_sel_i,
    input  logic [`VID_DATA_W-1:0]      wb_dat_i,
    output logic [`VID_DATA_W-1:0]      wb_dat_o,
    output logic                        wb_ack_o,
    input  logic                        host_grant_i,
    input  logic [`VID_DATA_W-1:0]      vram_rdata_i,   // valid cycle after grant
    input  logic [`VID_DATA_W-1:0]      xr_rdata_i,
    input  intr_t                       intr_signal_i,
    output logic                        host_req_o,
    output logic                        host_we_o,
    output logic [`VID_DATA_W/8-1:0]    host_be_o,
    output logic [`VID_VRAM_AW-1:0]     host_addr_o,
    output logic [`VID_DATA_W-1:0]      host_wdata_o,
    output logic                        xr_wr_o,
    output logic                        xr_addr_o,
    output logic [`VID_DATA_W-1:0]      xr_wdata_o,
    output logic                        pal_wr_o,
    output logic [`VID_PAL_AW-1:0]      pal_addr_o,
    output rgb_t                        pal_wdata_o,
    output logic                        bus_intr_o
);

    localparam int DW = `VID_DATA_W;
    localparam int IW = `VID_INTR_W;

    regs_state_e                state;
    vid_reg_e                   reg_num;
    logic                       start;          // new transfer, not during ack
    logic                       xr_access;
    logic [`VID_VRAM_AW-1:0]    vram_addr;
    logic [DW-1:0]              xr_addr;        // bit 15 selects palette
    intr_t                      intr_mask;
    intr_t                      intr_status;    // sticky until cleared
    intr_t                      intr_clear;
    logic [DW-1:0]              rd_mux;

    assign reg_num   = vid_reg_e'(wb_adr_i);
    assign start     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign xr_access = (state == ST_ACK) && (reg_num == REG_XR_DATA);

    // vram request, master holds its signals till ack
    assign host_req_o   = (state == ST_VRAM_WAIT);
    assign host_we_o    = wb_we_i;
    assign host_be_o    = wb_sel_i;
    assign host_addr_o  = vram_addr;
    assign host_wdata_o = wb_dat_i;

    // xr writes split on address bit 15
    assign xr_wr_o     = xr_access && wb_we_i && !xr_addr[DW-1];
    assign xr_addr_o   = xr_addr[0];
    assign xr_wdata_o  = wb_dat_i;
    assign pal_wr_o    = xr_access && wb_we_i && xr_addr[DW-1];
    assign pal_addr_o  = xr_addr[`VID_PAL_AW-1:0];
    assign pal_wdata_o = rgb_t'(wb_dat_i[3*`VID_COLOR_W-1:0]);   // 0x0RGB

    // ones in bits 11:8 clear status
    assign intr_clear = ((state == ST_ACK) && wb_we_i && (reg_num == REG_INTR)) ?
                        wb_dat_i[8 +: IW] : '0;

    always_comb begin
        rd_mux = '0;
        case (reg_num)
            REG_VRAM_ADDR: rd_mux = DW'(vram_addr);
            REG_XR_ADDR:   rd_mux = xr_addr;
            REG_XR_DATA:   rd_mux = xr_addr[DW-1] ? '0 : xr_rdata_i;    // palette reads 0
            REG_INTR: begin
                rd_mux[IW-1:0]  = intr_status;
                rd_mux[8 +: IW] = intr_mask;
            end
            default:       rd_mux = '0;
        endcase
    end

    // transfer sequencer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            wb_ack_o  <= 1'b0;
            vram_addr <= '0;
            xr_addr   <= '0;
            intr_mask <= '0;
        end else begin
            wb_ack_o <= 1'b0;                       // single cycle ack
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= (reg_num == REG_VRAM_DATA) ? ST_VRAM_WAIT : ST_ACK;
                    end
                end
                ST_VRAM_WAIT: begin
                    if (host_grant_i) begin         // at most 2 cycles behind video
                        vram_addr <= vram_addr + 1'b1;
                        state     <= wb_we_i ? ST_ACK : ST_VRAM_READ;
                    end
                end
                ST_VRAM_READ: state <= ST_ACK;
                ST_ACK: begin
                    wb_ack_o <= 1'b1;
                    state    <= ST_IDLE;
                    if (wb_we_i) begin
                        case (reg_num)
                            REG_VRAM_ADDR: vram_addr <= wb_dat_i[`VID_VRAM_AW-1:0];
                            REG_XR_ADDR:   xr_addr   <= wb_dat_i;
                            REG_INTR:      intr_mask <= wb_dat_i[IW-1:0];
                            default:       ;
                        endcase
                    end
                    if (reg_num == REG_XR_DATA) begin
                        xr_addr <= xr_addr + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read data, valid with ack
    always_ff @(posedge clk) begin
        if (state == ST_VRAM_READ) begin
            wb_dat_o <= vram_rdata_i;
        end else if ((state == ST_ACK) && (reg_num != REG_VRAM_DATA)) begin
            wb_dat_o <= rd_mux;
        end
    end

    // interrupt unit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status <= '0;
            bus_intr_o  <= 1'b0;
        end else begin
            bus_intr_o  <= |(intr_signal_i & intr_mask & ~intr_status);  // new, unmasked
            intr_status <= (intr_status | intr_signal_i) & ~intr_clear;
        end
    end

endmodule

// ==== vid_vram.sv ====
// video ram with fetch priority
`include "vid_config.svh"

module vid_vram (
    input  logic                        clk,
    input  logic                        video_req_i,    // always wins
    input  logic [`VID_VRAM_AW-1:0]     video_addr_i,
    input  logic                        host_req_i,
    input  logic                        host_we_i,
    input  logic [`VID_DATA_W/8-1:0]    host_be_i,      // per byte write enable
    input  logic [`VID_VRAM_AW-1:0]     host_addr_i,
    input  logic [`VID_DATA_W-1:0]      host_wdata_i,
    output logic                        host_grant_o,
    output logic [`VID_DATA_W-1:0]      rdata_o         // one cycle after access
);

    localparam int NB = `VID_DATA_W / 8;

    logic [`VID_DATA_W-1:0]     mem [1 << `VID_VRAM_AW];
    logic [`VID_VRAM_AW-1:0]    addr;
    logic                       wr_en;

    // host gets the port only in video-free cycles
    assign host_grant_o = host_req_i && !video_req_i;
    assign addr         = video_req_i ? video_addr_i : host_addr_i;
    assign wr_en        = host_grant_o && host_we_i;

    always_ff @(posedge clk) begin
        for (int b = 0; b < NB; b++) begin
            if (wr_en && host_be_i[b]) begin
                mem[addr][8*b +: 8] <= host_wdata_i[8*b +: 8];
            end
        end
        rdata_o <= mem[addr];                       // old data on a write
    end

endmodule
